// File: flist.f
+incdir+source
source/acf_types_pkg.sv
source/coef_bus_pkg.sv
source/acf_accumulator.sv
source/acf_normalizer.sv
source/coef_bus_arbiter.sv
source/coef_bank.sv
source/lpc_autocorr_top.sv
verification/lpc_autocorr_sva.sv
verification/lpc_autocorr_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the LPC autocorrelation testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f \
    --top-module lpc_autocorr_tb \
    -o lpc_autocorr_sim

./obj_dir/lpc_autocorr_sim 2>&1 | tee sim.log

if grep -qx "Simulation PASSED" sim.log; then
    echo "run_sim: testbench passed"
else
    echo "run_sim: testbench failed"
    exit 1
fi

// File: source/acf_accumulator.sv
// autocorrelation accumulator
// per-block lag products and running sums, snapshot taken at block end.
`timescale 1ns/1ps
`include "lpc_macros.svh"

module acf_accumulator #(
    parameter int block_size = `LPC_BLOCK_SIZE
) (
    input  logic                    iClock,
    input  logic                    rst,
    input  logic                    sample_strobe,
    input  acf_types_pkg::sample_t  sample,
    output acf_types_pkg::acf_sum_t acf_sums [0:`LPC_MAX_LAG],
    output logic                    block_ready
);

    localparam int CNT_W = (block_size > 1) ? $clog2(block_size) : 1;

    acf_types_pkg::sample_t  history   [0:`LPC_MAX_LAG-1];  // x[n-1] .. x[n-12].
    acf_types_pkg::product_t products  [0:`LPC_MAX_LAG];
    acf_types_pkg::acf_sum_t work_sums [0:`LPC_MAX_LAG];

    logic [CNT_W-1:0] sample_cnt;
    logic             last_strobe;
    logic             prod_valid;                        // products hold a sample.
    logic             prod_last;                         // that sample closed the block.

    assign last_strobe = sample_strobe && (sample_cnt == CNT_W'(block_size - 1));

    // strobe count and history line, history is emptied at each block start.
    always_ff @(posedge iClock) begin
        if (rst) begin
            sample_cnt <= '0;
            for (int k = 0; k < `LPC_MAX_LAG; k++) begin
                history[k] <= '0;
            end
        end else if (sample_strobe) begin
            if (last_strobe) begin
                sample_cnt <= '0;
                for (int k = 0; k < `LPC_MAX_LAG; k++) begin
                    history[k] <= '0;
                end
            end else begin
                sample_cnt <= sample_cnt + 1'b1;
                history[0] <= sample;
                for (int k = 1; k < `LPC_MAX_LAG; k++) begin
                    history[k] <= history[k-1];
                end
            end
        end
    end

    // product stage, one row of 13 products per strobe.
    always_ff @(posedge iClock) begin
        if (sample_strobe) begin
            products[0] <= sample * sample;               // lag 0 is the energy term.
            for (int k = 1; k <= `LPC_MAX_LAG; k++) begin
                products[k] <= sample * history[k-1];
            end
        end
    end

    always_ff @(posedge iClock) begin
        if (rst) begin
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= sample_strobe;
            prod_last  <= last_strobe;
        end
    end

    // running sums, the closing row goes straight into the snapshot.
    always_ff @(posedge iClock) begin
        if (rst) begin
            block_ready <= 1'b0;
            for (int k = 0; k <= `LPC_MAX_LAG; k++) begin
                work_sums[k] <= '0;
            end
        end else begin
            block_ready <= prod_valid && prod_last;
            if (prod_valid) begin
                for (int k = 0; k <= `LPC_MAX_LAG; k++) begin
                    if (prod_last) begin
                        work_sums[k] <= '0;               // next block starts clean.
                    end else begin
                        work_sums[k] <= work_sums[k] + acf_types_pkg::acf_sum_t'(products[k]);
                    end
                end
            end
        end
    end

    // snapshot, held until the next block end.
    always_ff @(posedge iClock) begin
        if (prod_valid && prod_last) begin
            for (int k = 0; k <= `LPC_MAX_LAG; k++) begin
                acf_sums[k] <= work_sums[k] + acf_types_pkg::acf_sum_t'(products[k]);
            end
        end
    end

endmodule

// File: source/acf_normalizer.sv
// autocorrelation normalizer
// serial restoring divide of each lag by lag 0 into saturated q1.15 writes.
`timescale 1ns/1ps
`include "lpc_macros.svh"

module acf_normalizer (
    input  logic                      iClock,
    input  logic                      rst,
    input  acf_types_pkg::acf_sum_t   acf_sums [0:`LPC_MAX_LAG],
    input  logic                      block_ready,
    output logic                      wr_req,
    output coef_bus_pkg::coef_addr_t  wr_addr,
    output coef_bus_pkg::coef_t       wr_data,
    input  logic                      wr_grant,
    output logic                      done,
    output logic                      block_dropped
);

    localparam int SUM_W  = acf_types_pkg::ACF_SUM_W;
    localparam int STEP_W = $clog2(`LPC_DIV_STEPS);

    typedef enum logic [1:0] {ST_IDLE, ST_LOAD, ST_DIV, ST_WRITE} state_t;

    state_t                   state;
    acf_types_pkg::acf_sum_t  snap [0:`LPC_MAX_LAG];
    acf_types_pkg::lag_t      lag;
    logic [STEP_W-1:0]        step;
    logic [SUM_W-1:0]         den;                       // |acf[0]|.
    logic [SUM_W:0]           rem;                       // partial remainder, one spare bit.
    logic [`LPC_DIV_STEPS-1:0] quo;
    logic                     num_neg;
    logic                     rem_ge;
    logic [SUM_W:0]           rem_sub;
    logic [`LPC_DIV_STEPS-1:0] quo_next;
    coef_bus_pkg::coef_t      coef_next;

    function automatic logic [SUM_W-1:0] magnitude(input acf_types_pkg::acf_sum_t v);
        return v[SUM_W-1] ? SUM_W'(-v) : SUM_W'(v);
    endfunction

    // saturate to 32767 then apply the sign. the result never drops below -32767.
    function automatic coef_bus_pkg::coef_t to_coef(input logic [`LPC_DIV_STEPS-1:0] q,
                                                    input logic neg,
                                                    input logic den_zero);
        logic [`LPC_COEF_FRAC-1:0] mag;
        if (den_zero) begin
            return '0;
        end
        mag = (|q[`LPC_DIV_STEPS-1:`LPC_COEF_FRAC]) ? '1 : q[`LPC_COEF_FRAC-1:0];
        return neg ? -coef_bus_pkg::coef_t'({1'b0, mag}) : coef_bus_pkg::coef_t'({1'b0, mag});
    endfunction

    assign rem_ge    = rem >= {1'b0, den};
    assign rem_sub   = rem_ge ? rem - {1'b0, den} : rem;
    assign quo_next  = {quo[`LPC_DIV_STEPS-2:0], rem_ge};
    assign coef_next = to_coef(quo_next, num_neg, den == '0);
    assign wr_addr   = coef_bus_pkg::coef_addr_t'(lag);  // lag and address share a width.

    always_ff @(posedge iClock) begin
        if (block_ready && state == ST_IDLE) begin
            snap <= acf_sums;
        end
    end

    // lag walk and write handshake.
    always_ff @(posedge iClock) begin
        if (rst) begin
            state         <= ST_IDLE;
            lag           <= '0;
            step          <= '0;
            wr_req        <= 1'b0;
            done          <= 1'b0;
            block_dropped <= 1'b0;
        end else begin
            done          <= 1'b0;
            block_dropped <= block_ready && (state != ST_IDLE);  // overrun, run continues.
            case (state)
                ST_IDLE: begin
                    if (block_ready) begin
                        lag   <= '0;
                        state <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    step  <= '0;
                    state <= ST_DIV;
                end
                ST_DIV: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(`LPC_DIV_STEPS - 1)) begin
                        wr_req <= 1'b1;
                        state  <= ST_WRITE;
                    end
                end
                ST_WRITE: begin
                    if (wr_grant) begin
                        wr_req <= 1'b0;
                        if (lag == acf_types_pkg::lag_t'(`LPC_MAX_LAG)) begin
                            done  <= 1'b1;
                            state <= ST_IDLE;
                        end else begin
                            lag   <= lag + 1'b1;
                            state <= ST_LOAD;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // divider datapath, one quotient bit per cycle.
    always_ff @(posedge iClock) begin
        if (state == ST_LOAD) begin
            den     <= magnitude(snap[0]);
            rem     <= {1'b0, magnitude(snap[lag])};
            num_neg <= snap[lag][SUM_W-1];
            quo     <= '0;
        end else if (state == ST_DIV) begin
            rem <= {rem_sub[SUM_W-1:0], 1'b0};
            quo <= quo_next;
            if (step == STEP_W'(`LPC_DIV_STEPS - 1)) begin
                wr_data <= coef_next;                     // held through the write request.
            end
        end
    end

endmodule

// File: source/acf_types_pkg.sv
// autocorrelation arithmetic types
// sample, lag product, block sum and lag index widths.
`include "lpc_macros.svh"

package acf_types_pkg;

    localparam int SAMPLE_W  = 16;                 // one input word.
    localparam int PRODUCT_W = 2 * SAMPLE_W;       // full signed product.

    // product bits, block growth bits and one guard bit.
    localparam int ACF_SUM_W = PRODUCT_W + $clog2(`LPC_BLOCK_SIZE) + 1;

    localparam int LAG_W = $clog2(`LPC_MAX_LAG + 1);

    typedef logic signed [SAMPLE_W-1:0]  sample_t;
    typedef logic signed [PRODUCT_W-1:0] product_t;
    typedef logic signed [ACF_SUM_W-1:0] acf_sum_t;
    typedef logic [LAG_W-1:0]            lag_t;

endpackage

// File: source/coef_bank.sv
// coefficient bank
// thirteen q1.15 registers behind one port with registered read.
`timescale 1ns/1ps
`include "lpc_macros.svh"

module coef_bank (
    input  logic                     iClock,
    input  logic                     rst,
    input  logic                     bank_en,
    input  logic                     bank_we,
    input  coef_bus_pkg::coef_addr_t bank_addr,
    input  coef_bus_pkg::coef_t      bank_wdata,
    output coef_bus_pkg::coef_t      bank_rdata
);

    coef_bus_pkg::coef_t coef_regs [0:`LPC_MAX_LAG];
    logic                addr_ok;

    assign addr_ok = bank_addr <= coef_bus_pkg::coef_addr_t'(`LPC_MAX_LAG);

    always_ff @(posedge iClock) begin
        if (rst) begin
            bank_rdata <= '0;
            for (int k = 0; k <= `LPC_MAX_LAG; k++) begin
                coef_regs[k] <= '0;
            end
        end else if (bank_en) begin
            if (bank_we) begin
                if (addr_ok) begin
                    coef_regs[bank_addr] <= bank_wdata;   // out of range writes are dropped.
                end
            end else begin
                bank_rdata <= addr_ok ? coef_regs[bank_addr] : '0;
            end
        end
    end

endmodule

// File: source/coef_bus_arbiter.sv
// coefficient bank arbiter
// fixed priority, host read over normalizer write, on the single bank port.
`timescale 1ns/1ps

module coef_bus_arbiter (
    input  logic                     iClock,
    input  logic                     rst,
    input  logic                     host_rd_req,
    input  coef_bus_pkg::coef_addr_t host_rd_addr,
    output logic                     host_rd_grant,
    output logic                     host_rd_valid,
    input  logic                     wr_req,
    input  coef_bus_pkg::coef_addr_t wr_addr,
    input  coef_bus_pkg::coef_t      wr_data,
    output logic                     wr_grant,
    output logic                     bank_en,
    output logic                     bank_we,
    output coef_bus_pkg::coef_addr_t bank_addr,
    output coef_bus_pkg::coef_t      bank_wdata
);

    coef_bus_pkg::bus_owner_t owner;

    // host wins ties, the normalizer simply keeps its request up.
    always_comb begin
        if (host_rd_req) begin
            owner = coef_bus_pkg::OWNER_HOST;
        end else if (wr_req) begin
            owner = coef_bus_pkg::OWNER_NORMALIZER;
        end else begin
            owner = coef_bus_pkg::OWNER_NONE;
        end
    end

    assign host_rd_grant = (owner == coef_bus_pkg::OWNER_HOST);
    assign wr_grant      = (owner == coef_bus_pkg::OWNER_NORMALIZER);

    assign bank_en    = (owner != coef_bus_pkg::OWNER_NONE);
    assign bank_we    = wr_grant;
    assign bank_addr  = host_rd_grant ? host_rd_addr : wr_addr;
    assign bank_wdata = wr_data;

    // bank read is registered, so data shows up one cycle after the grant.
    always_ff @(posedge iClock) begin
        if (rst) begin
            host_rd_valid <= 1'b0;
        end else begin
            host_rd_valid <= host_rd_grant;
        end
    end

endmodule

// File: source/coef_bus_pkg.sv
// coefficient bank bus types
// q1.15 data word, bank address and port owner encoding.
`include "lpc_macros.svh"

package coef_bus_pkg;

    localparam int COEF_W      = `LPC_COEF_FRAC + 1;      // sign plus fraction.
    localparam int COEF_ADDR_W = $clog2(`LPC_MAX_LAG + 1);

    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic [COEF_ADDR_W-1:0]   coef_addr_t;

    typedef enum logic [1:0] {
        OWNER_NONE       = 2'd0,
        OWNER_HOST       = 2'd1,
        OWNER_NORMALIZER = 2'd2
    } bus_owner_t;

endpackage

// File: source/lpc_autocorr_top.sv
// lpc autocorrelation front end
// accumulator, normalizer and host-shared coefficient bank.
`timescale 1ns/1ps
`include "lpc_macros.svh"

module lpc_autocorr_top #(
    parameter int block_size = `LPC_BLOCK_SIZE
) (
    input  logic                     iClock,
    input  logic                     rst,
    input  logic                     sample_strobe,
    input  acf_types_pkg::sample_t   sample,
    input  logic                     host_rd_req,
    input  coef_bus_pkg::coef_addr_t host_rd_addr,
    output logic                     host_rd_grant,
    output logic                     host_rd_valid,
    output coef_bus_pkg::coef_t      host_rd_data,
    output logic                     done,
    output logic                     block_dropped
);

    acf_types_pkg::acf_sum_t  acf_sums [0:`LPC_MAX_LAG];
    logic                     block_ready;
    logic                     wr_req;
    coef_bus_pkg::coef_addr_t wr_addr;
    coef_bus_pkg::coef_t      wr_data;
    logic                     wr_grant;
    logic                     bank_en;
    logic                     bank_we;
    coef_bus_pkg::coef_addr_t bank_addr;
    coef_bus_pkg::coef_t      bank_wdata;

    acf_accumulator #(
        .block_size (block_size)
    ) acc0 (
        .iClock        (iClock),
        .rst           (rst),
        .sample_strobe (sample_strobe),
        .sample        (sample),
        .acf_sums      (acf_sums),
        .block_ready   (block_ready)
    );

    acf_normalizer norm0 (
        .iClock        (iClock),
        .rst           (rst),
        .acf_sums      (acf_sums),
        .block_ready   (block_ready),
        .wr_req        (wr_req),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_grant      (wr_grant),
        .done          (done),
        .block_dropped (block_dropped)
    );

    coef_bus_arbiter arb0 (
        .iClock        (iClock),
        .rst           (rst),
        .host_rd_req   (host_rd_req),
        .host_rd_addr  (host_rd_addr),
        .host_rd_grant (host_rd_grant),
        .host_rd_valid (host_rd_valid),
        .wr_req        (wr_req),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_grant      (wr_grant),
        .bank_en       (bank_en),
        .bank_we       (bank_we),
        .bank_addr     (bank_addr),
        .bank_wdata    (bank_wdata)
    );

    coef_bank bank0 (
        .iClock     (iClock),
        .rst        (rst),
        .bank_en    (bank_en),
        .bank_we    (bank_we),
        .bank_addr  (bank_addr),
        .bank_wdata (bank_wdata),
        .bank_rdata (host_rd_data)                        // host sees the bank read port.
    );

endmodule

// File: source/lpc_macros.svh
// lpc autocorrelation sizes
// lag count, block length, coefficient format and divider depth.
`ifndef LPC_MACROS_SVH
`define LPC_MACROS_SVH

// highest lag computed, lags 0..12 are produced.
`define LPC_MAX_LAG 12

// default samples per block.
`define LPC_BLOCK_SIZE 4096

// fraction bits of a q1.15 coefficient.
`define LPC_COEF_FRAC 15

// quotient bits produced per lag by the serial divider.
`define LPC_DIV_STEPS 16

`endif

// File: verification/lpc_autocorr_sva.sv
// coefficient bus arbiter assertions
// grant exclusivity, request pairing, read valid timing and held writes.
`timescale 1ns/1ps

module lpc_autocorr_sva (
    input logic                     iClock,
    input logic                     rst,
    input logic                     host_rd_req,
    input logic                     host_rd_grant,
    input logic                     host_rd_valid,
    input logic                     wr_req,
    input coef_bus_pkg::coef_addr_t wr_addr,
    input coef_bus_pkg::coef_t      wr_data,
    input logic                     wr_grant,
    input coef_bus_pkg::bus_owner_t owner
);

    a_one_grant: assert property (@(posedge iClock) disable iff (rst)
        !(host_rd_grant && wr_grant))
        else $error("host read grant and normalizer write grant are high together");

    a_host_grant_req: assert property (@(posedge iClock) disable iff (rst)
        host_rd_grant |-> host_rd_req && owner == coef_bus_pkg::OWNER_HOST)
        else $error("host read grant without a host request");

    a_wr_grant_req: assert property (@(posedge iClock) disable iff (rst)
        wr_grant |-> wr_req && owner == coef_bus_pkg::OWNER_NORMALIZER)
        else $error("write grant without a normalizer request");

    a_valid_after_grant: assert property (@(posedge iClock) disable iff (rst)
        host_rd_grant |=> host_rd_valid)
        else $error("host read valid missing one cycle after grant");

    a_valid_needs_grant: assert property (@(posedge iClock) disable iff (rst)
        host_rd_valid |-> $past(host_rd_grant))
        else $error("host read valid without a grant in the previous cycle");

    // a waiting write keeps its request, address and data.
    a_wr_held: assert property (@(posedge iClock) disable iff (rst)
        wr_req && !wr_grant |=> wr_req && $stable(wr_addr) && $stable(wr_data))
        else $error("pending write request changed before its grant");

endmodule

bind coef_bus_arbiter lpc_autocorr_sva sva0 (
    .iClock        (iClock),
    .rst           (rst),
    .host_rd_req   (host_rd_req),
    .host_rd_grant (host_rd_grant),
    .host_rd_valid (host_rd_valid),
    .wr_req        (wr_req),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data),
    .wr_grant      (wr_grant),
    .owner         (owner)
);

// File: verification/lpc_autocorr_tb.sv
// lpc autocorrelation testbench
// directed block tests against a software model of the lag sums and coefficients.
`timescale 1ns/1ps
`include "lpc_macros.svh"

module lpc_autocorr_tb;

    localparam int BLOCK          = 64;
    localparam int LAGS           = `LPC_MAX_LAG + 1;
    localparam int TIMEOUT_CYCLES = 6 * (BLOCK + 260) + 1000;  // six blocks plus read margin.
    localparam logic [31:0] LFSR_MASK = 32'h80200003;         // x^32 + x^22 + x^2 + x + 1.

    logic                     iClock;
    logic                     rst;
    logic                     sample_strobe;
    acf_types_pkg::sample_t   sample;
    logic                     host_rd_req;
    coef_bus_pkg::coef_addr_t host_rd_addr;
    logic                     host_rd_grant;
    logic                     host_rd_valid;
    coef_bus_pkg::coef_t      host_rd_data;
    logic                     done;
    logic                     block_dropped;

    acf_types_pkg::sample_t blk [0:BLOCK-1];                  // samples of the block in test.
    int                     exp_coef [0:LAGS-1];
    logic [31:0]            lfsr_state;
    int                     cycle_cnt = 0;
    int                     done_cnt = 0;
    int                     drop_cnt = 0;

    lpc_autocorr_top #(
        .block_size (BLOCK)
    ) dut0 (
        .iClock        (iClock),
        .rst           (rst),
        .sample_strobe (sample_strobe),
        .sample        (sample),
        .host_rd_req   (host_rd_req),
        .host_rd_addr  (host_rd_addr),
        .host_rd_grant (host_rd_grant),
        .host_rd_valid (host_rd_valid),
        .host_rd_data  (host_rd_data),
        .done          (done),
        .block_dropped (block_dropped)
    );

    initial begin
        iClock = 1'b0;
        forever #5 iClock = ~iClock;
    end

    // pulse counters that the tests read on the falling edge.
    always @(posedge iClock) begin
        if (done) done_cnt <= done_cnt + 1;
        if (block_dropped) drop_cnt <= drop_cnt + 1;
    end

    always @(posedge iClock) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", cycle_cnt);
            $display("Simulation FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string what, input longint expected, input longint actual);
        if (expected != actual) begin
            $display("Error at time %0t: %s, expected %0d, got %0d", $time, what, expected,
                     actual);
            $display("Simulation FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LFSR_MASK) : (s >> 1);
    endfunction

    task automatic random_sample(output acf_types_pkg::sample_t v);
        for (int b = 0; b < 16; b++) begin
            v[b]       = lfsr_state[0];                       // one step per bit taken.
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // truncated, saturated and signed q1.15 value of num/den.
    function automatic int coef_rule(input longint num, input longint den);
        longint mag;
        longint q;
        if (den == 0) begin
            return 0;
        end
        mag = (num < 0) ? -num : num;
        q   = (mag << `LPC_COEF_FRAC) / den;
        if (q > 32767) q = 32767;
        if (num < 0) q = -q;
        if (q < -32768) q = -32768;
        return int'(q);
    endfunction

    task automatic build_model();
        longint acf [0:LAGS-1];
        for (int k = 0; k < LAGS; k++) begin
            acf[k] = 0;
            for (int n = k; n < BLOCK; n++) begin
                acf[k] += longint'(blk[n]) * longint'(blk[n-k]);  // pairs inside the block only.
            end
            exp_coef[k] = coef_rule(acf[k], acf[0]);
        end
    endtask

    task automatic stream_block();
        for (int n = 0; n < BLOCK; n++) begin
            @(negedge iClock);
            sample_strobe = 1'b1;
            sample        = blk[n];
        end
    endtask

    task automatic stop_stream();
        @(negedge iClock);
        sample_strobe = 1'b0;
        sample        = '0;
    endtask

    task automatic wait_done(input int start);
        while (done_cnt == start) begin
            @(negedge iClock);
        end
    endtask

    // grant is combinational on the request and data comes one cycle later.
    task automatic read_coef(input int addr, output int value);
        @(negedge iClock);
        host_rd_req  = 1'b1;
        host_rd_addr = coef_bus_pkg::coef_addr_t'(addr);
        #1;
        check_value($sformatf("read grant at address %0d", addr), 1, longint'(host_rd_grant));
        @(negedge iClock);
        host_rd_req = 1'b0;
        check_value($sformatf("read valid at address %0d", addr), 1, longint'(host_rd_valid));
        value = int'(host_rd_data);
    endtask

    task automatic check_bank();
        int value;
        for (int k = 0; k < LAGS; k++) begin
            read_coef(k, value);
            check_value($sformatf("coefficient lag %0d", k), longint'(exp_coef[k]),
                        longint'(value));
        end
    endtask

    task automatic run_block();
        int start;
        start = done_cnt;
        build_model();
        stream_block();
        stop_stream();
        wait_done(start);
        check_bank();
    endtask

    task automatic reset_state_clear();
        for (int k = 0; k < LAGS; k++) exp_coef[k] = 0;
        repeat (20) @(negedge iClock);
        check_value("done pulses after reset", 0, longint'(done_cnt));
        check_value("dropped blocks after reset", 0, longint'(drop_cnt));
        check_bank();
    endtask

    task automatic impulse_and_constant_blocks();
        for (int n = 0; n < BLOCK; n++) blk[n] = '0;
        blk[10] = -16'sd12345;
        run_block();
        for (int n = 0; n < BLOCK; n++) blk[n] = 16'sd1000;   // lags fall off as (64-k)/64.
        run_block();
    endtask

    task automatic random_block_coefs();
        for (int n = 0; n < BLOCK; n++) random_sample(blk[n]);
        run_block();
    endtask

    task automatic silent_block_zero();
        for (int n = 0; n < BLOCK; n++) blk[n] = '0;
        run_block();
    endtask

    task automatic reads_during_normalize();
        int start;
        int value;
        int addr;
        for (int n = 0; n < BLOCK; n++) random_sample(blk[n]);
        build_model();
        start = done_cnt;
        stream_block();
        stop_stream();
        addr = 0;
        while (done_cnt == start) begin
            read_coef(addr, value);                           // every other cycle.
            addr = (addr + 1) % LAGS;
        end
        check_bank();
    endtask

    task automatic overrun_drops_block();
        int start;
        int drops;
        for (int n = 0; n < BLOCK; n++) random_sample(blk[n]);
        build_model();                                        // only the first block lands.
        start = done_cnt;
        drops = drop_cnt;
        stream_block();
        for (int n = 0; n < BLOCK; n++) random_sample(blk[n]);
        stream_block();
        stop_stream();
        wait_done(start);
        repeat (4) @(negedge iClock);
        check_value("done pulses for two streamed blocks", 1, longint'(done_cnt - start));
        check_value("dropped blocks", 1, longint'(drop_cnt - drops));
        check_bank();
    endtask

    initial begin
        rst           = 1'b1;
        sample_strobe = 1'b0;
        sample        = '0;
        host_rd_req   = 1'b0;
        host_rd_addr  = '0;
        lfsr_state    = 32'h0e96e263;
        repeat (2) @(negedge iClock);
        rst = 1'b0;

        reset_state_clear();
        impulse_and_constant_blocks();
        random_block_coefs();
        silent_block_zero();
        reads_during_normalize();
        overrun_drops_block();

        $display("Simulation PASSED");
        $finish;
    end

endmodule
